//--- Makefile
TOP = tb_dncnn_conv
SIM = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard hw/*.sv test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: $(SIM)
	./$(SIM) | awk '{ print } /^\*\* PASS \*\*$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- hw/act_window.sv
`timescale 1ns/1ps

module act_window import dncnn_pkg::*; (
    input  logic                    clk,
    input  logic                    load,
    input  logic                    pad,
    input  logic [WORD_W-1:0]       rdata0,
    input  logic [WORD_W-1:0]       rdata1,
    output logic signed [PIX_W-1:0] act0,
    output logic signed [PIX_W-1:0] act1,
    output logic signed [PIX_W-1:0] act2
);

    logic [WORDS_PER_ROW*WORD_W-1:0] row_bits;
    logic [(IMG_W+2)*PIX_W-1:0]      padded;
    logic [(IMG_W+2)*PIX_W-1:0]      win;

    // Even word holds the left half of the row
    assign row_bits = {rdata1, rdata0};

    // Zero pixel on each side, whole row zero above or below the image
    always_comb begin
        padded = '0;
        if (!pad) begin
            padded[(IMG_W+1)*PIX_W-1:PIX_W] = row_bits[IMG_W*PIX_W-1:0];
        end
    end

    // Lowest byte is the left neighbour of the current column
    always_ff @(posedge clk) begin
        if (load) begin
            win <= padded;
        end else begin
            win <= win >> PIX_W;
        end
    end

    assign act0 = $signed(win[PIX_W-1:0]);
    assign act1 = $signed(win[2*PIX_W-1:PIX_W]);
    assign act2 = $signed(win[3*PIX_W-1:2*PIX_W]);

endmodule

//--- hw/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl import dncnn_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     compute_start,
    input  logic [WORD_W-1:0]        sram_weight_rdata,
    output logic                     compute_finish,
    output logic [ADDR_W-1:0]        sram_weight_addr,
    output logic [ADDR_W-1:0]        sram_act_addr0,
    output logic [ADDR_W-1:0]        sram_act_addr1,
    output logic [WORD_W/8-1:0]      sram_act_wea0,
    output logic [WORD_W/8-1:0]      sram_act_wea1,
    output logic                     load,
    output logic                     pad,
    output logic                     cal_en,
    output logic                     acc_en,
    output logic [$clog2(IMG_W)-1:0] col,
    output logic                     quant_en,
    output logic                     clear,
    output logic [K_SIZE*PIX_W-1:0]  weight_row
);

    localparam int COL_W = $clog2(IMG_W);
    // Read, load, eight columns, then PE latency of three
    localparam int PASS_CYCLES = 13;
    localparam int LOAD_STEP = 1;
    localparam int CAL_FIRST = 2;
    localparam int ACC_FIRST = CAL_FIRST + 3;

    state_t                   state;
    logic [3:0]               step;
    logic [$clog2(IMG_H)-1:0] row;
    logic [1:0]               pass;
    logic [$clog2(IMG_H)-1:0] in_row;
    logic [ADDR_W-1:0]        rd_base;
    logic [ADDR_W-1:0]        wr_base;
    logic [K_SIZE*PIX_W-1:0]  weights [K_SIZE];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step <= '0;
            row <= '0;
            pass <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (compute_start) begin
                        state <= READ_WEIGHT;
                        step <= '0;
                        row <= '0;
                        pass <= '0;
                    end
                end
                READ_WEIGHT: begin
                    if (step == 4'(K_SIZE)) begin
                        state <= CALCULATE;
                        step <= '0;
                    end else begin
                        step <= step + 4'd1;
                    end
                end
                CALCULATE: begin
                    if (step == 4'(PASS_CYCLES - 1)) begin
                        step <= '0;
                        if (pass == 2'(K_SIZE - 1)) begin
                            pass <= '0;
                            state <= QUANTIZE;
                        end else begin
                            pass <= pass + 2'd1;
                        end
                    end else begin
                        step <= step + 4'd1;
                    end
                end
                QUANTIZE: state <= WRITE_OUTPUT;
                WRITE_OUTPUT: begin
                    if (row == 3'(IMG_H - 1)) begin
                        state <= FINISH;
                    end else begin
                        row <= row + 3'd1;
                        state <= CALCULATE;
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Weight data lags its address by one step
    always_ff @(posedge clk) begin
        if (state == READ_WEIGHT && step != '0) begin
            weights[step[1:0] - 2'd1] <= sram_weight_rdata[K_SIZE*PIX_W-1:0];
        end
    end

    assign weight_row = weights[pass];
    assign sram_weight_addr = (state == READ_WEIGHT && step < 4'(K_SIZE)) ?
                              ADDR_W'(step) : '0;

    // Input row feeding this kernel row
    assign in_row = row + 3'(pass) - 3'd1;
    assign pad = (pass == 2'd0 && row == '0) || (pass == 2'(K_SIZE - 1) && row == 3'(IMG_H - 1));
    assign rd_base = ADDR_W'(WORDS_PER_ROW * in_row);
    assign wr_base = ADDR_W'(OUT_BASE + WORDS_PER_ROW * row);

    always_comb begin
        sram_act_addr0 = '0;
        sram_act_addr1 = '0;
        if (state == CALCULATE && !pad) begin
            sram_act_addr0 = rd_base;
            sram_act_addr1 = rd_base + ADDR_W'(1);
        end else if (state == WRITE_OUTPUT) begin
            sram_act_addr0 = wr_base;
            sram_act_addr1 = wr_base + ADDR_W'(1);
        end
    end

    assign sram_act_wea0 = {(WORD_W/8){state == WRITE_OUTPUT}};
    assign sram_act_wea1 = {(WORD_W/8){state == WRITE_OUTPUT}};

    assign load = (state == CALCULATE) && (step == 4'(LOAD_STEP));
    assign cal_en = (state == CALCULATE) && (step >= 4'(CAL_FIRST)) &&
                    (step < 4'(CAL_FIRST + IMG_W));
    assign acc_en = (state == CALCULATE) && (step >= 4'(ACC_FIRST)) &&
                    (step < 4'(ACC_FIRST + IMG_W));
    assign col = COL_W'(step - 4'(ACC_FIRST));
    assign quant_en = (state == QUANTIZE);
    assign clear = (state == WRITE_OUTPUT);
    assign compute_finish = (state == FINISH);

endmodule

//--- hw/dncnn_conv.sv
`timescale 1ns/1ps

module dncnn_conv import dncnn_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                compute_start,
    output logic                compute_finish,
    input  logic [31:0]         scale,
    output logic [ADDR_W-1:0]   sram_weight_addr,
    input  logic [WORD_W-1:0]   sram_weight_rdata,
    output logic [WORD_W/8-1:0] sram_act_wea0,
    output logic [ADDR_W-1:0]   sram_act_addr0,
    output logic [WORD_W-1:0]   sram_act_wdata0,
    input  logic [WORD_W-1:0]   sram_act_rdata0,
    output logic [WORD_W/8-1:0] sram_act_wea1,
    output logic [ADDR_W-1:0]   sram_act_addr1,
    output logic [WORD_W-1:0]   sram_act_wdata1,
    input  logic [WORD_W-1:0]   sram_act_rdata1
);

    logic                     load;
    logic                     pad;
    logic                     cal_en;
    logic                     acc_en;
    logic [$clog2(IMG_W)-1:0] col;
    logic                     quant_en;
    logic                     clear;
    logic [K_SIZE*PIX_W-1:0]  weight_row;
    logic signed [PIX_W-1:0]  act0;
    logic signed [PIX_W-1:0]  act1;
    logic signed [PIX_W-1:0]  act2;
    logic signed [PSUM_W-1:0] psum;

    conv_ctrl ctrl_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .compute_start     (compute_start),
        .sram_weight_rdata (sram_weight_rdata),
        .compute_finish    (compute_finish),
        .sram_weight_addr  (sram_weight_addr),
        .sram_act_addr0    (sram_act_addr0),
        .sram_act_addr1    (sram_act_addr1),
        .sram_act_wea0     (sram_act_wea0),
        .sram_act_wea1     (sram_act_wea1),
        .load              (load),
        .pad               (pad),
        .cal_en            (cal_en),
        .acc_en            (acc_en),
        .col               (col),
        .quant_en          (quant_en),
        .clear             (clear),
        .weight_row        (weight_row)
    );

    act_window window_i (
        .clk    (clk),
        .load   (load),
        .pad    (pad),
        .rdata0 (sram_act_rdata0),
        .rdata1 (sram_act_rdata1),
        .act0   (act0),
        .act1   (act1),
        .act2   (act2)
    );

    // One PE reused for each kernel row
    pe pe_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cal_en     (cal_en),
        .act0       (act0),
        .act1       (act1),
        .act2       (act2),
        .weight_row (weight_row),
        .psum       (psum)
    );

    psum_row psum_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_en   (acc_en),
        .col      (col),
        .psum     (psum),
        .quant_en (quant_en),
        .clear    (clear),
        .scale    (scale),
        .wdata0   (sram_act_wdata0),
        .wdata1   (sram_act_wdata1)
    );

endmodule

//--- hw/dncnn_pkg.sv
package dncnn_pkg;

    localparam int IMG_W = 8;
    localparam int IMG_H = 8;
    localparam int PIX_W = 8;
    localparam int PSUM_W = 32;
    localparam int WORD_W = 32;
    localparam int ADDR_W = 16;
    localparam int WORDS_PER_ROW = 2;
    localparam int OUT_BASE = 16;
    localparam int K_SIZE = 3;
    localparam int QUANT_SHIFT = 16;
    localparam int ACT_MAX = 127;

    typedef enum logic [2:0] {
        IDLE,
        READ_WEIGHT,
        CALCULATE,
        QUANTIZE,
        WRITE_OUTPUT,
        FINISH
    } state_t;

    // ReLU, scale, shift and saturate one partial sum
    function automatic logic [PIX_W-1:0] requant(
        input logic signed [PSUM_W-1:0] sum,
        input logic signed [31:0]       scale
    );
        logic signed [2*PSUM_W-1:0] prod;
        logic signed [2*PSUM_W-1:0] shifted;
        prod = sum * scale;
        shifted = prod >>> QUANT_SHIFT;
        if (sum <= 0) begin
            return '0;
        end else if (shifted > ACT_MAX) begin
            return PIX_W'(ACT_MAX);
        end
        return shifted[PIX_W-1:0];
    endfunction

endpackage

//--- hw/pe.sv
`timescale 1ns/1ps

module pe import dncnn_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cal_en,
    input  logic signed [PIX_W-1:0]  act0,
    input  logic signed [PIX_W-1:0]  act1,
    input  logic signed [PIX_W-1:0]  act2,
    input  logic [K_SIZE*PIX_W-1:0]  weight_row,
    output logic signed [PSUM_W-1:0] psum
);

    logic signed [2*PIX_W-1:0] prod0;
    logic signed [2*PIX_W-1:0] prod1;
    logic signed [2*PIX_W-1:0] prod2;
    logic signed [2*PIX_W+1:0] sum;
    logic                      prod_vld;
    logic                      sum_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_vld <= 1'b0;
            sum_vld <= 1'b0;
        end else begin
            prod_vld <= cal_en;
            sum_vld <= prod_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (cal_en) begin
            prod0 <= act0 * $signed(weight_row[PIX_W-1:0]);
            prod1 <= act1 * $signed(weight_row[2*PIX_W-1:PIX_W]);
            prod2 <= act2 * $signed(weight_row[3*PIX_W-1:2*PIX_W]);
        end
        if (prod_vld) begin
            sum <= prod0 + prod1 + prod2;
        end
        if (sum_vld) begin
            psum <= PSUM_W'(sum);
        end
    end

endmodule

//--- hw/psum_row.sv
`timescale 1ns/1ps

module psum_row import dncnn_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     acc_en,
    input  logic [$clog2(IMG_W)-1:0] col,
    input  logic signed [PSUM_W-1:0] psum,
    input  logic                     quant_en,
    input  logic                     clear,
    input  logic signed [31:0]       scale,
    output logic [WORD_W-1:0]        wdata0,
    output logic [WORD_W-1:0]        wdata1
);

    logic signed [PSUM_W-1:0]  sums [IMG_W];
    logic [IMG_W*PIX_W-1:0]    packed_row;

    // Clear follows the write of the finished row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < IMG_W; i++) begin
                sums[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < IMG_W; i++) begin
                sums[i] <= '0;
            end
        end else if (quant_en) begin
            for (int i = 0; i < IMG_W; i++) begin
                sums[i] <= PSUM_W'(requant(sums[i], scale));
            end
        end else if (acc_en) begin
            sums[col] <= sums[col] + psum;
        end
    end

    // Leftmost pixel in the lowest byte
    always_comb begin
        packed_row = '0;
        for (int i = 0; i < IMG_W; i++) begin
            packed_row[i*PIX_W +: PIX_W] = sums[i][PIX_W-1:0];
        end
    end

    assign wdata0 = packed_row[WORD_W-1:0];
    assign wdata1 = packed_row[2*WORD_W-1:WORD_W];

endmodule

//--- sources.f
hw/dncnn_pkg.sv
hw/conv_ctrl.sv
hw/act_window.sv
hw/pe.sv
hw/psum_row.sv
hw/dncnn_conv.sv
test/tb_dncnn_conv.sv

//--- test/tb_dncnn_conv.sv
`timescale 1ns/1ps

module tb_dncnn_conv import dncnn_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_RUNS = 11;
    localparam int RUN_BOUND = 3000;

    logic        clk;
    logic        rst_n;
    logic        compute_start;
    logic        compute_finish;
    logic [31:0] scale;
    logic [15:0] sram_weight_addr;
    logic [31:0] sram_weight_rdata = '0;
    logic [3:0]  sram_act_wea0;
    logic [15:0] sram_act_addr0;
    logic [31:0] sram_act_wdata0;
    logic [31:0] sram_act_rdata0 = '0;
    logic [3:0]  sram_act_wea1;
    logic [15:0] sram_act_addr1;
    logic [31:0] sram_act_wdata1;
    logic [31:0] sram_act_rdata1 = '0;

    // Loading port into the activation memory
    logic        host_we;
    logic [4:0]  host_addr;
    logic [31:0] host_wdata;

    logic [31:0]       act_mem [32];
    logic signed [7:0] img [IMG_H][IMG_W];
    logic signed [7:0] kern [K_SIZE][K_SIZE];
    logic [31:0]       scl;
    integer            seed;
    int                runs_checked = 0;
    logic              finish_prev = 1'b0;

    dncnn_conv dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .compute_start     (compute_start),
        .compute_finish    (compute_finish),
        .scale             (scale),
        .sram_weight_addr  (sram_weight_addr),
        .sram_weight_rdata (sram_weight_rdata),
        .sram_act_wea0     (sram_act_wea0),
        .sram_act_addr0    (sram_act_addr0),
        .sram_act_wdata0   (sram_act_wdata0),
        .sram_act_rdata0   (sram_act_rdata0),
        .sram_act_wea1     (sram_act_wea1),
        .sram_act_addr1    (sram_act_addr1),
        .sram_act_wdata1   (sram_act_wdata1),
        .sram_act_rdata1   (sram_act_rdata1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] weight_word(input logic [15:0] addr);
        if (addr < 16'd3) begin
            return {8'h00, kern[addr[1:0]][2], kern[addr[1:0]][1], kern[addr[1:0]][0]};
        end
        return 32'h0;
    endfunction

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        if (host_we) begin
            act_mem[host_addr] <= host_wdata;
        end
        for (int b = 0; b < 4; b++) begin
            if (sram_act_wea0[b]) begin
                act_mem[sram_act_addr0[4:0]][8*b +: 8] <= sram_act_wdata0[8*b +: 8];
            end
            if (sram_act_wea1[b]) begin
                act_mem[sram_act_addr1[4:0]][8*b +: 8] <= sram_act_wdata1[8*b +: 8];
            end
        end
        sram_act_rdata0 <= act_mem[sram_act_addr0[4:0]];
        sram_act_rdata1 <= act_mem[sram_act_addr1[4:0]];
        sram_weight_rdata <= weight_word(sram_weight_addr);
    end

    function automatic logic [31:0] image_word(input int a);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = img[a / 2][4 * (a % 2) + i];
        end
        return w;
    endfunction

    // 3x3 window with zero border, then ReLU, scale, shift and clip
    function automatic logic [7:0] expected_pixel(input int r, input int c);
        longint acc;
        longint scaled;
        int     ir;
        int     ic;
        acc = 0;
        for (int kr = 0; kr < K_SIZE; kr++) begin
            for (int kc = 0; kc < K_SIZE; kc++) begin
                ir = r + kr - 1;
                ic = c + kc - 1;
                if (ir >= 0 && ir < IMG_H && ic >= 0 && ic < IMG_W) begin
                    acc = acc + longint'(img[ir][ic]) * longint'(kern[kr][kc]);
                end
            end
        end
        if (acc <= 0) begin
            return 8'd0;
        end
        scaled = (acc * longint'(scl)) >>> QUANT_SHIFT;
        if (scaled > ACT_MAX) begin
            return 8'(ACT_MAX);
        end
        return 8'(scaled);
    endfunction

    function automatic logic [31:0] expected_word(input int a);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = expected_pixel(a / 2, 4 * (a % 2) + i);
        end
        return w;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    // Compare the whole memory once per finish pulse
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(compute_finish && finish_prev)) else
                fail_run($sformatf("ERROR at %0d ns: compute_finish longer than one cycle",
                                   $time));
            finish_prev <= compute_finish;
            if (compute_finish) begin
                for (int a = 0; a < 16; a++) begin
                    assert (act_mem[a] == image_word(a)) else
                        fail_run($sformatf("ERROR at %0d ns: input word %0d is %08h, not %08h",
                                           $time, a, act_mem[a], image_word(a)));
                end
                for (int a = 0; a < 16; a++) begin
                    assert (act_mem[OUT_BASE + a] == expected_word(a)) else
                        fail_run($sformatf("ERROR at %0d ns: word %0d is %08h, expected %08h",
                                           $time, OUT_BASE + a, act_mem[OUT_BASE + a],
                                           expected_word(a)));
                end
                runs_checked <= runs_checked + 1;
            end
        end
    end

    // 0 random, 1 small positive, 2 large positive, 3 negative
    task automatic fill_image(input int kind);
        logic [7:0] r;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                r = 8'($random(seed));
                case (kind)
                    0: img[y][x] = r;
                    1: img[y][x] = {5'd0, r[2:0]} + 8'd1;
                    2: img[y][x] = {2'b01, r[5:0]};
                    default: img[y][x] = -8'sd1 - $signed({1'b0, r[6:0]});
                endcase
            end
        end
    endtask

    // 0 identity, 1 random, 2 all ones, 3 all 127
    task automatic set_kernel(input int kind);
        logic [7:0] r;
        for (int kr = 0; kr < K_SIZE; kr++) begin
            for (int kc = 0; kc < K_SIZE; kc++) begin
                r = 8'($random(seed));
                case (kind)
                    0: kern[kr][kc] = (kr == 1 && kc == 1) ? 8'sd1 : 8'sd0;
                    1: kern[kr][kc] = r;
                    2: kern[kr][kc] = 8'sd1;
                    default: kern[kr][kc] = 8'sd127;
                endcase
            end
        end
    endtask

    // Image in words 0 to 15, marker pattern over the output words
    task automatic load_memory();
        for (int a = 0; a < 32; a++) begin
            @(posedge clk);
            host_we <= 1'b1;
            host_addr <= 5'(a);
            if (a < 16) begin
                host_wdata <= image_word(a);
            end else begin
                host_wdata <= 32'hA5A5_0000 | 32'(a);
            end
        end
        @(posedge clk);
        host_we <= 1'b0;
        scale <= scl;
    endtask

    task automatic run_conv(input bit extra_start);
        int target;
        target = runs_checked + 1;
        @(posedge clk);
        compute_start <= 1'b1;
        @(posedge clk);
        compute_start <= 1'b0;
        if (extra_start) begin
            // A start in mid run must be ignored
            repeat (50) @(posedge clk);
            compute_start <= 1'b1;
            @(posedge clk);
            compute_start <= 1'b0;
        end
        wait (runs_checked == target);
    endtask

    initial begin
        #(CLK_PERIOD * (NUM_RUNS * RUN_BOUND + 10));
        $display("Timeout: compute_finish never came within %0d runs", NUM_RUNS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'h3961;
        compute_start = 1'b0;
        scale = '0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Identity kernel at unit scale
        fill_image(0);
        set_kernel(0);
        scl = 32'd65536;
        load_memory();
        run_conv(1'b0);

        repeat (5) begin
            fill_image(0);
            set_kernel(1);
            scl = ($random(seed) & 32'h1ff) + 32'd1;
            load_memory();
            run_conv(1'b0);
        end

        // Border padding shows in the corner and edge sums
        fill_image(1);
        set_kernel(2);
        scl = 32'd65536;
        load_memory();
        run_conv(1'b0);

        // Saturation, then all sums negative
        fill_image(2);
        set_kernel(3);
        scl = 32'h0010_0000;
        load_memory();
        run_conv(1'b0);
        fill_image(3);
        load_memory();
        run_conv(1'b0);

        // Repeated start, then a second run on the same image
        fill_image(0);
        set_kernel(1);
        scl = ($random(seed) & 32'h1ff) + 32'd1;
        load_memory();
        run_conv(1'b1);
        load_memory();
        run_conv(1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule
